// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := core_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+include
hw/core_pkg.sv
hw/ifetch.sv
hw/decode.sv
hw/exec.sv
hw/int_regfile.sv
hw/core.sv
sim/core_props.sv
sim/core_tb.sv

// File: hw/core.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module core import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             imem_ack,
    input  logic [`ILEN-1:0] imem_rdata,
    input  logic [4:0]       reg_read_sel,
    output logic             imem_req,
    output logic [`ALEN-1:0] imem_addr,
    output logic [`XLEN-1:0] reg_read_data,
    output logic [`ALEN-1:0] reg_pc,
    output retire_t          retire,
    output logic             retire_valid
);

    // ******************************
    // Register clear after reset
    // ******************************

    logic [4:0] reg_to_clear;
    logic       do_clear_regs;

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_to_clear  <= 5'd31;
            do_clear_regs <= 1'b1;
        end else if (do_clear_regs) begin
            reg_to_clear <= reg_to_clear - 5'd1;
            if (reg_to_clear == 5'd1)
                do_clear_regs <= 1'b0;  // x1 was the last one
        end
    end

    fetch_pkt_t       fetch_pkt;
    logic             fetch_stall_next;
    logic             fetch_next_stalled;
    dec_pkt_t         dec_pkt;
    logic             dec_stall_next;
    logic             dec_next_stalled;
    logic [4:0]       rs1_sel, rs2_sel;
    logic [`XLEN-1:0] rs1_data, rs2_data;
    logic             exec_wr_en;
    logic [4:0]       exec_wr_sel;
    logic [`XLEN-1:0] exec_wr_data;

    ifetch i_ifetch (
        .clk,
        .rst,
        .flush        (do_clear_regs),  // No fetch until registers are clear
        .next_stalled (fetch_next_stalled),
        .imem_ack,
        .imem_rdata,
        .imem_req,
        .imem_addr,
        .pc           (reg_pc),
        .pkt          (fetch_pkt),
        .stall_next   (fetch_stall_next)
    );

    decode i_decode (
        .clk,
        .rst,
        .in_pkt       (fetch_pkt),
        .prev_stalled (fetch_stall_next),
        .next_stalled (dec_next_stalled),
        .rs1_data,
        .rs2_data,
        .fwd          (retire),
        .fwd_valid    (retire_valid),
        .stall_prev   (fetch_next_stalled),
        .stall_next   (dec_stall_next),
        .rs1_sel,
        .rs2_sel,
        .out_pkt      (dec_pkt)
    );

    exec i_exec (
        .clk,
        .rst,
        .in_pkt       (dec_pkt),
        .prev_stalled (dec_stall_next),
        .stall_prev   (dec_next_stalled),
        .wr_en        (exec_wr_en),
        .wr_sel       (exec_wr_sel),
        .wr_data      (exec_wr_data),
        .retire,
        .retire_valid
    );

    // Clear sequencer owns the write port while active
    int_regfile i_regs (
        .clk,
        .write_enable (do_clear_regs ? 1'b1 : exec_wr_en),
        .write_sel    (do_clear_regs ? reg_to_clear : exec_wr_sel),
        .write_data   (do_clear_regs ? '0 : exec_wr_data),
        .read1_sel    (rs1_sel),
        .read2_sel    (rs2_sel),
        .read3_sel    (reg_read_sel),
        .read1_data   (rs1_data),
        .read2_data   (rs2_data),
        .read3_data   (reg_read_data)
    );

endmodule

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none
`include "core_defs.svh"

package core_pkg;

    // ******************************
    // Instruction word views
    // ******************************

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;  // Bits 31..20
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Same 32 bits, register or immediate layout
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // ******************************
    // Stage payloads
    // ******************************

    typedef struct packed {
        instr_t           instruction;
        logic [`ALEN-1:0] addr;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_t          alu_op;
        logic [4:0]       rd;
        logic             reg_write;
        logic [`XLEN-1:0] op_a;
        logic [`XLEN-1:0] op_b;
        logic [`ALEN-1:0] addr;
    } dec_pkt_t;

    typedef struct packed {
        logic [`ALEN-1:0] addr;
        logic [4:0]       rd;
        logic             reg_write;
        logic [`XLEN-1:0] data;
    } retire_t;

endpackage

`default_nettype wire

// File: hw/decode.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module decode import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkt_t       in_pkt,
    input  logic             prev_stalled,
    input  logic             next_stalled,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  retire_t          fwd,
    input  logic             fwd_valid,
    output logic             stall_prev,
    output logic             stall_next,
    output logic [4:0]       rs1_sel,
    output logic [4:0]       rs2_sel,
    output dec_pkt_t         out_pkt
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    instr_t   ins;
    dec_pkt_t dec;
    logic     use1, use2;     // Operand comes from a register
    logic     valid;
    dec_pkt_t pkt_q;
    logic [4:0] src1_q, src2_q;
    logic     use1_q, use2_q;
    logic     hit1, hit2;
    logic [`XLEN-1:0] fwd_a, fwd_b;

    assign ins     = in_pkt.instruction;
    assign rs1_sel = ins.r_fmt.rs1;
    assign rs2_sel = ins.r_fmt.rs2;

    // ******************************
    // Instruction decode
    // ******************************

    always_comb begin
        dec.alu_op    = ALU_NOP;
        dec.rd        = ins.r_fmt.rd;
        dec.reg_write = 1'b0;
        dec.op_a      = rs1_data;
        dec.op_b      = rs2_data;
        dec.addr      = in_pkt.addr;
        use1          = 1'b0;
        use2          = 1'b0;
        case (ins.r_fmt.opcode)
            OPC_OP: begin
                use1          = 1'b1;
                use2          = 1'b1;
                dec.reg_write = 1'b1;
                case (ins.r_fmt.funct3)
                    3'b000:  dec.alu_op = ins.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  dec.alu_op = ALU_SLL;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b011:  dec.alu_op = ALU_SLTU;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b101:  dec.alu_op = ins.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  dec.alu_op = ALU_OR;
                    default: dec.alu_op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                use1          = 1'b1;
                dec.reg_write = 1'b1;
                dec.op_b      = {{(`XLEN-12){ins.i_fmt.imm12[11]}}, ins.i_fmt.imm12};
                case (ins.i_fmt.funct3)
                    3'b000:  dec.alu_op = ALU_ADD;
                    3'b001:  dec.alu_op = ALU_SLL;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b011:  dec.alu_op = ALU_SLTU;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b101:  dec.alu_op = ins.i_fmt.imm12[10] ? ALU_SRA : ALU_SRL;
                    3'b110:  dec.alu_op = ALU_OR;
                    default: dec.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                // Upper immediate is bits 31..12, added to zero
                dec.alu_op    = ALU_ADD;
                dec.reg_write = 1'b1;
                dec.op_a      = '0;
                dec.op_b      = {ins.i_fmt.imm12, ins.i_fmt.rs1, ins.i_fmt.funct3, 12'b0};
            end
            default: ;  // Retires as a no-op
        endcase
        if (dec.rd == 5'd0)
            dec.reg_write = 1'b0;
    end

    // ******************************
    // Skid register and forwarding
    // ******************************

    assign stall_prev = valid && next_stalled;
    assign stall_next = !valid;

    // Exec result not yet in the register file when this entry was read
    assign hit1  = fwd_valid && fwd.reg_write && use1_q && (src1_q != 5'd0) && (fwd.rd == src1_q);
    assign hit2  = fwd_valid && fwd.reg_write && use2_q && (src2_q != 5'd0) && (fwd.rd == src2_q);
    assign fwd_a = hit1 ? fwd.data : pkt_q.op_a;
    assign fwd_b = hit2 ? fwd.data : pkt_q.op_b;

    always_comb begin
        out_pkt      = pkt_q;
        out_pkt.op_a = fwd_a;
        out_pkt.op_b = fwd_b;
    end

    always_ff @(posedge clk) begin
        if (rst)
            valid <= 1'b0;
        else if (!stall_prev)
            valid <= !prev_stalled;
    end

    always_ff @(posedge clk) begin
        if (!stall_prev && !prev_stalled) begin
            pkt_q  <= dec;
            src1_q <= rs1_sel;
            src2_q <= rs2_sel;
            use1_q <= use1;
            use2_q <= use2;
        end else if (stall_prev) begin
            pkt_q.op_a <= fwd_a;  // Keep forwarded value while held
            pkt_q.op_b <= fwd_b;
        end
    end

endmodule

`default_nettype wire

// File: hw/exec.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module exec import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  dec_pkt_t         in_pkt,
    input  logic             prev_stalled,
    output logic             stall_prev,
    output logic             wr_en,
    output logic [4:0]       wr_sel,
    output logic [`XLEN-1:0] wr_data,
    output retire_t          retire,
    output logic             retire_valid
);

    logic [`XLEN-1:0] result;
    logic [4:0]       shamt;
    logic             take;

    assign shamt      = in_pkt.op_b[4:0];
    assign take       = !prev_stalled;
    assign stall_prev = 1'b0;  // Single-cycle ALU, always ready

    // ******************************
    // ALU
    // ******************************

    always_comb begin
        case (in_pkt.alu_op)
            ALU_ADD:  result = in_pkt.op_a + in_pkt.op_b;
            ALU_SUB:  result = in_pkt.op_a - in_pkt.op_b;
            ALU_SLL:  result = in_pkt.op_a << shamt;
            ALU_SLT:  begin
                result = {{(`XLEN-1){1'b0}}, $signed(in_pkt.op_a) < $signed(in_pkt.op_b)};
            end
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, in_pkt.op_a < in_pkt.op_b};
            ALU_XOR:  result = in_pkt.op_a ^ in_pkt.op_b;
            ALU_SRL:  result = in_pkt.op_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(in_pkt.op_a) >>> shamt);
            ALU_OR:   result = in_pkt.op_a | in_pkt.op_b;
            ALU_AND:  result = in_pkt.op_a & in_pkt.op_b;
            default:  result = '0;  // NOP
        endcase
    end

    // Register file write, same edge as the retire register
    assign wr_en   = take && in_pkt.reg_write && (in_pkt.rd != 5'd0);
    assign wr_sel  = in_pkt.rd;
    assign wr_data = result;

    // ******************************
    // Retire register
    // ******************************

    always_ff @(posedge clk) begin
        if (rst)
            retire_valid <= 1'b0;
        else
            retire_valid <= take;  // One pulse per instruction
    end

    always_ff @(posedge clk) begin
        if (take) begin
            retire.addr      <= in_pkt.addr;
            retire.rd        <= in_pkt.rd;
            retire.reg_write <= wr_en;
            retire.data      <= result;
        end
    end

endmodule

`default_nettype wire

// File: hw/ifetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module ifetch import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             next_stalled,
    input  logic             imem_ack,
    input  logic [`ILEN-1:0] imem_rdata,
    output logic             imem_req,
    output logic [`ALEN-1:0] imem_addr,
    output logic [`ALEN-1:0] pc,
    output fetch_pkt_t       pkt,
    output logic             stall_next
);

    // Four-phase bus states
    localparam logic [1:0] ST_IDLE = 2'd0;  // req low, waiting for a free slot
    localparam logic [1:0] ST_REQ  = 2'd1;  // req high, waiting for ack
    localparam logic [1:0] ST_DONE = 2'd2;  // req dropped, waiting for ack low

    logic [1:0] state;
    logic       valid;      // Output register holds a packet
    logic       slot_free;  // Output register empty by the next edge
    logic       capture;

    assign slot_free = !valid || !next_stalled;
    assign capture   = (state == ST_REQ) && imem_ack;

    assign imem_req   = (state == ST_REQ);
    assign imem_addr  = pc;  // Stable while req is high
    assign stall_next = !valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= ST_IDLE;
            valid <= 1'b0;
            pc    <= '0;
        end else begin
            if (!next_stalled)
                valid <= 1'b0;  // Taken by decode
            case (state)
                ST_IDLE: begin
                    if (slot_free)
                        state <= ST_REQ;
                end
                ST_REQ: begin
                    if (imem_ack) begin
                        state <= ST_DONE;
                        valid <= 1'b1;
                        pc    <= pc + 32'd4;
                    end
                end
                ST_DONE: begin
                    // New req only once the responder has let go of ack
                    if (!imem_ack)
                        state <= slot_free ? ST_REQ : ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pkt.instruction <= instr_t'(imem_rdata);
            pkt.addr        <= pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/int_regfile.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module int_regfile (
    input  logic             clk,
    input  logic             write_enable,
    input  logic [4:0]       write_sel,
    input  logic [`XLEN-1:0] write_data,
    input  logic [4:0]       read1_sel,
    input  logic [4:0]       read2_sel,
    input  logic [4:0]       read3_sel,
    output logic [`XLEN-1:0] read1_data,
    output logic [`XLEN-1:0] read2_data,
    output logic [`XLEN-1:0] read3_data
);

    // x1..x31, x0 has no storage
    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (write_enable && (write_sel != 5'd0))
            regs[write_sel] <= write_data;
    end

    // Asynchronous reads
    assign read1_data = (read1_sel == 5'd0) ? '0 : regs[read1_sel];
    assign read2_data = (read2_sel == 5'd0) ? '0 : regs[read2_sel];
    assign read3_data = (read3_sel == 5'd0) ? '0 : regs[read3_sel];  // Debug port

endmodule

`default_nettype wire

// File: include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// ******************************
// Machine word widths
// ******************************

`define XLEN 32  // Data word
`define ILEN 32  // Instruction word
`define ALEN 32  // Address word

`endif

// File: sim/core_props.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module core_props import core_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             imem_req,
    input logic             imem_ack,
    input logic [`ALEN-1:0] imem_addr,
    input retire_t          retire,
    input logic             retire_valid
);

    // ******************************
    // Fetch bus, four-phase
    // ******************************

    req_held: assert property (@(posedge clk) disable iff (rst)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before imem_ack rose");

    // Address may only move once the word is captured
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        imem_req && !imem_ack |=> $stable(imem_addr))
        else $error("imem_addr changed while imem_req was high");

    // ******************************
    // Retire port
    // ******************************

    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !retire_valid)
        else $error("retire_valid high during reset");

    no_x0_write: assert property (@(posedge clk)
        retire_valid |-> !(retire.reg_write && retire.rd == 5'd0))
        else $error("retire reports a write to x0");

endmodule

bind core core_props i_core_props (
    .clk          (clk),
    .rst          (rst),
    .imem_req     (imem_req),
    .imem_ack     (imem_ack),
    .imem_addr    (imem_addr),
    .retire       (retire),
    .retire_valid (retire_valid)
);

`default_nettype wire

// File: sim/core_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module core_tb import core_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 16;
    localparam int PROG_LEN    = 300;
    localparam int CHAIN_LEN   = 100;    // Dependent chain at zero fetch latency
    localparam int RUN_TIMEOUT = 20000;
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;  // addi x0, x0, 0

    logic             clk;
    logic             rst;
    logic             imem_ack;
    logic [`ILEN-1:0] imem_rdata;
    logic [4:0]       reg_read_sel;
    logic             imem_req;
    logic [`ALEN-1:0] imem_addr;
    logic [`XLEN-1:0] reg_read_data;
    logic [`ALEN-1:0] reg_pc;
    retire_t          retire;
    logic             retire_valid;

    logic [31:0]      prog [0:PROG_LEN-1];
    logic [`XLEN-1:0] model_regs [0:31];
    logic             mem_enable;
    int               retired;

    core i_core (
        .clk,
        .rst,
        .imem_ack,
        .imem_rdata,
        .reg_read_sel,
        .imem_req,
        .imem_addr,
        .reg_read_data,
        .reg_pc,
        .retire,
        .retire_valid
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ******************************
    // Error reporting
    // ******************************

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("ERROR: %s", what);
        stop_with_failure();
    endtask

    // ******************************
    // Program generator
    // ******************************

    function automatic logic [31:0] make_instr(input logic chain, input logic [4:0] prev_rd);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  opc;
        int          kind;
        r    = $urandom;
        s    = $urandom;
        kind = $urandom_range(0, 15);
        rd   = {2'b00, r[2:0]};  // x0..x7 keeps dependencies dense
        rs1  = chain ? prev_rd : {2'b00, r[5:3]};
        rs2  = (chain && r[29]) ? prev_rd : {2'b00, r[8:6]};
        f3   = r[11:9];
        imm  = r[23:12];
        if (kind < 7) begin
            return {((f3 == 3'd0 || f3 == 3'd5) && r[28]) ? 7'h20 : 7'h00,
                    rs2, rs1, f3, rd, 7'h33};
        end else if (kind < 13) begin
            if (f3 == 3'd1)
                imm = {7'h00, imm[4:0]};
            else if (f3 == 3'd5)
                imm = {r[28] ? 7'h20 : 7'h00, imm[4:0]};  // SRLI or SRAI
            return {imm, rs1, f3, rd, 7'h13};
        end else if (kind == 13) begin
            return {s[31:12], rd, 7'h37};
        end
        case (r[30:28])  // Opcodes the core does not implement
            3'd0:    opc = 7'h03;
            3'd1:    opc = 7'h23;
            3'd2:    opc = 7'h63;
            3'd3:    opc = 7'h6f;
            3'd4:    opc = 7'h17;
            3'd5:    opc = 7'h73;
            3'd6:    opc = 7'h67;
            default: opc = 7'h0f;
        endcase
        return {s[31:7], opc};
    endfunction

    task automatic build_program();
        logic [4:0] prev_rd;
        prev_rd = 5'd1;
        for (int n = 0; n < PROG_LEN; n++) begin
            prog[n] = make_instr(n < CHAIN_LEN, prev_rd);
            prev_rd = prog[n][11:7];
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if ((addr >> 2) < PROG_LEN)
            return prog[addr[10:2]];
        return NOP_WORD;
    endfunction

    // ******************************
    // Reference model
    // ******************************

    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];  // Sign bit fills from the left
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model(input logic [31:0] w, output logic [4:0] rd,
                             output logic we, output logic [31:0] data);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        rd  = w[11:7];
        we  = 1'b1;
        case (w[6:0])
            7'h33:   data = alu_result(w[14:12], w[30], a, b);
            7'h13:   data = alu_result(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm);
            7'h37:   data = {w[31:12], 12'h000};
            default: begin
                we   = 1'b0;
                data = '0;
            end
        endcase
        if (rd == 5'd0)
            we = 1'b0;  // x0 hardwired
    endtask

    // ******************************
    // Fetch bus responder
    // ******************************

    function automatic int pick_latency(input logic [31:0] addr);
        if (addr < CHAIN_LEN * 4)
            return 0;
        return $urandom_range(0, 3);
    endfunction

    initial begin
        int          wait_cycles;
        logic [31:0] fetch_addr;
        imem_ack    = 1'b0;
        imem_rdata  = '0;
        wait_cycles = -1;
        fetch_addr  = '0;
        forever begin
            @(negedge clk);
            if (imem_ack) begin
                if (!imem_req)
                    imem_ack = 1'b0;  // Phase 4
            end else if (imem_req && mem_enable) begin
                if (wait_cycles < 0)
                    wait_cycles = pick_latency(imem_addr);
                if (wait_cycles == 0) begin
                    assert (imem_addr == fetch_addr)
                    else report_mismatch("imem_addr", imem_addr, fetch_addr);
                    imem_ack    = 1'b1;
                    imem_rdata  = fetch_word(imem_addr);
                    fetch_addr  = fetch_addr + 32'd4;
                    wait_cycles = -1;
                end else begin
                    wait_cycles--;
                end
            end
        end
    end

    // Retire monitor, sampled mid-cycle
    initial begin
        logic [31:0] next_addr;
        logic [4:0]  exp_rd;
        logic        exp_we;
        logic [31:0] exp_data;
        next_addr = '0;
        retired   = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        forever begin
            @(negedge clk);
            if (!rst && retire_valid) begin
                assert (retire.addr == next_addr)
                else report_mismatch("retire.addr", retire.addr, next_addr);
                run_model(fetch_word(next_addr), exp_rd, exp_we, exp_data);
                assert (retire.rd == exp_rd)
                else report_mismatch("retire.rd", 32'(retire.rd), 32'(exp_rd));
                assert (retire.reg_write == exp_we)
                else report_mismatch("retire.reg_write", 32'(retire.reg_write), 32'(exp_we));
                if (exp_we) begin
                    assert (retire.data == exp_data)
                    else report_mismatch("retire.data", retire.data, exp_data);
                    model_regs[exp_rd] = exp_data;
                end
                next_addr = next_addr + 32'd4;
                retired++;
            end
        end
    end

    task automatic check_reg(input int idx, input logic [31:0] exp);
        @(negedge clk);
        reg_read_sel = 5'(idx);
        #(CLK_PERIOD / 4);
        assert (reg_read_data == exp)
        else report_mismatch($sformatf("reg_read_data x%0d", idx), reg_read_data, exp);
    endtask

    // Reset, wait out the clear period, then expect an empty register file
    task automatic reset_and_check_clear();
        int cycles;
        mem_enable = 1'b0;
        rst        = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        // First request marks the end of the clear period
        cycles = 0;
        while (!imem_req && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (!imem_req)
            report_problem("no fetch request after the register clear period");
        assert (reg_pc == '0) else report_mismatch("reg_pc", reg_pc, 32'h0);
        for (int i = 0; i < 32; i++)
            check_reg(i, 32'h0);
    endtask

    // ******************************
    // Main sequence
    // ******************************

    initial begin
        int cycles;
        void'($urandom(32'hed419e0c));
        rst          = 1'b1;
        reg_read_sel = '0;
        mem_enable   = 1'b0;
        build_program();
        reset_and_check_clear();

        mem_enable = 1'b1;
        cycles     = 0;
        while (retired < PROG_LEN && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (retired < PROG_LEN)
            report_problem("program did not retire before the timeout");

        for (int i = 0; i < 32; i++)
            check_reg(i, model_regs[i]);  // Final state against the model

        // Registers now hold program results, so the clear has work to do
        @(negedge clk);
        reset_and_check_clear();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
